/* verilog/cpuPkg.sv */
package cpuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and memory sizes
  localparam int dataWidth    = 16;   // word and address width
  localparam int regAddrWidth = 4;    // 16 registers
  localparam int imemDepth    = 256;  // instruction words
  localparam int dmemDepth    = 256;  // data words
  localparam int dmemLatency  = 3;    // busy cycles per data access
  localparam int pcStep       = 2;    // byte step per instruction

  // forwarding selects into execute
  localparam logic [1:0] fwdNone = 2'd0;
  localparam logic [1:0] fwdMem  = 2'd1;  // from EX/MEM
  localparam logic [1:0] fwdWb   = 2'd2;  // from MEM/WB

  ////////////////////////////////////////////////////////////////////////////
  // instruction encodings, top nibble of the word
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    XOR = 4'h2,
    SLL = 4'h4,
    SRA = 4'h5,
    LW  = 4'h8,
    SW  = 4'h9,
    LLB = 4'hA,
    LHB = 4'hB,
    B   = 4'hC,
    HLT = 4'hF
  } opcodeT;

  // alu operation picked in decode
  typedef enum logic [2:0] {
    aluAdd, aluSub, aluXor, aluSll, aluSra, aluPassB, aluLlb, aluLhb
  } aluOpT;

  // branch condition, bits 11:9 of a B word
  typedef enum logic [2:0] {
    NEQ, EQ, GT, LT, GTE, LTE, OVFL, UNCOND
  } brCondT;

endpackage

/* verilog/alu.sv */
module alu (
  input  cpuPkg::aluOpT                aluOp,
  input  logic [cpuPkg::dataWidth-1:0] a,
  input  logic [cpuPkg::dataWidth-1:0] b,
  output logic [cpuPkg::dataWidth-1:0] result,
  output logic                         zero,
  output logic                         overflow,
  output logic                         negative
);
  import cpuPkg::*;

  logic [dataWidth-1:0] sum, diff, satVal;
  logic                 sumOvf, diffOvf;
  logic [$clog2(dataWidth)-1:0] shamt;

  assign sum   = a + b;
  assign diff  = a - b;
  assign shamt = b[$clog2(dataWidth)-1:0];  // low 4 bits

  // signed overflow, operand signs vs result sign
  assign sumOvf  = (a[dataWidth-1] == b[dataWidth-1]) && (sum[dataWidth-1] != a[dataWidth-1]);
  assign diffOvf = (a[dataWidth-1] != b[dataWidth-1]) && (diff[dataWidth-1] != a[dataWidth-1]);
  // clamp toward the side of a
  assign satVal  = {a[dataWidth-1], {(dataWidth-1){~a[dataWidth-1]}}};

  always_comb begin
    overflow = 1'b0;
    unique case (aluOp)
      aluAdd: begin
        result   = sumOvf ? satVal : sum;
        overflow = sumOvf;
      end
      aluSub: begin
        result   = diffOvf ? satVal : diff;
        overflow = diffOvf;
      end
      aluXor:   result = a ^ b;
      aluSll:   result = a << shamt;
      aluSra:   result = $signed(a) >>> shamt;
      aluPassB: result = b;
      aluLlb:   result = {a[dataWidth-1:dataWidth/2], b[dataWidth/2-1:0]}; // new low byte
      aluLhb:   result = {b[dataWidth/2-1:0], a[dataWidth/2-1:0]};         // new high byte
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[dataWidth-1];

endmodule

/* verilog/registerFile.sv */
module registerFile (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cpuPkg::regAddrWidth-1:0] srcReg1,
  input  logic [cpuPkg::regAddrWidth-1:0] srcReg2,
  input  logic [cpuPkg::regAddrWidth-1:0] dstReg,
  input  logic                            writeReg,
  input  logic [cpuPkg::dataWidth-1:0]    dstData,
  output logic [cpuPkg::dataWidth-1:0]    srcData1,
  output logic [cpuPkg::dataWidth-1:0]    srcData2
);
  import cpuPkg::*;

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  always_ff @(posedge clk) begin
    if (reset)
      regs <= '{default: '0};
    else if (writeReg && dstReg != '0)
      regs[dstReg] <= dstData;  // r0 stays zero
  end

  // r0 reads zero, a same-cycle write shows through
  function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] src);
    if (src == '0)
      return '0;
    if (writeReg && dstReg == src)
      return dstData;
    return regs[src];
  endfunction

  always_comb begin
    srcData1 = readPort(srcReg1);
    srcData2 = readPort(srcReg2);
  end

endmodule

/* verilog/instrDecoder.sv */
module instrDecoder (
  input  logic [cpuPkg::dataWidth-1:0]    instr,
  output cpuPkg::opcodeT                  opcode,
  output logic [cpuPkg::regAddrWidth-1:0] rd,
  output logic [cpuPkg::regAddrWidth-1:0] rs,
  output logic [cpuPkg::regAddrWidth-1:0] rt,
  output logic [cpuPkg::dataWidth-1:0]    imm,
  output cpuPkg::brCondT                  brCond,
  output logic [8:0]                      brOff,
  output logic                            regWrite,
  output logic                            memToReg,
  output logic                            memWrite,
  output logic                            memRead,
  output logic                            aluSrc,
  output logic                            branch,
  output logic                            halt,
  output cpuPkg::aluOpT                   aluOp
);
  import cpuPkg::*;

  logic byteImm;  // LLB / LHB carry an 8-bit immediate

  assign opcode  = opcodeT'(instr[15:12]);
  assign byteImm = opcode inside {LLB, LHB};

  ////////////////////////////////////////////////////////////////////////////
  // fields
  assign rd = instr[11:8];
  // LLB/LHB modify rd in place, so rd is also operand a
  assign rs = byteImm ? instr[11:8] : instr[7:4];
  assign rt = (opcode inside {SW, LLB, LHB}) ? instr[11:8] : instr[3:0];
  assign imm = byteImm ? {{(dataWidth-8){instr[7]}}, instr[7:0]}
                       : {{(dataWidth-4){instr[3]}}, instr[3:0]}; // offset or shamt
  assign brCond = brCondT'(instr[11:9]);
  assign brOff  = instr[8:0];

  ////////////////////////////////////////////////////////////////////////////
  // controls
  always_comb begin
    {regWrite, memToReg, memWrite, memRead, aluSrc, branch, halt} = '0;
    aluOp = aluPassB;
    case (opcode)
      ADD: begin regWrite = 1'b1; aluOp = aluAdd; end
      SUB: begin regWrite = 1'b1; aluOp = aluSub; end
      XOR: begin regWrite = 1'b1; aluOp = aluXor; end
      SLL: begin regWrite = 1'b1; aluSrc = 1'b1; aluOp = aluSll; end
      SRA: begin regWrite = 1'b1; aluSrc = 1'b1; aluOp = aluSra; end
      LW: begin
        regWrite = 1'b1;
        memToReg = 1'b1;
        memRead  = 1'b1;
        aluSrc   = 1'b1;
        aluOp    = aluAdd;            // base + offset
      end
      SW: begin memWrite = 1'b1; aluSrc = 1'b1; aluOp = aluAdd; end
      LLB: begin regWrite = 1'b1; aluSrc = 1'b1; aluOp = aluLlb; end
      LHB: begin regWrite = 1'b1; aluSrc = 1'b1; aluOp = aluLhb; end
      B:   branch = 1'b1;
      HLT: halt = 1'b1;
      default: ;                      // spare encodings run as nops
    endcase
  end

endmodule

/* verilog/hazardUnit.sv */
module hazardUnit (
  input  logic [cpuPkg::regAddrWidth-1:0] rsD,
  input  logic [cpuPkg::regAddrWidth-1:0] rtD,
  input  logic [cpuPkg::regAddrWidth-1:0] rsE,
  input  logic [cpuPkg::regAddrWidth-1:0] rtE,
  input  logic                            memReadE,
  input  logic                            regWriteM,
  input  logic                            regWriteW,
  input  logic [cpuPkg::regAddrWidth-1:0] writeRegE,
  input  logic [cpuPkg::regAddrWidth-1:0] writeRegM,
  input  logic [cpuPkg::regAddrWidth-1:0] writeRegW,
  input  logic                            branchTakenE,
  output logic                            stallF,
  output logic                            stallD,
  output logic                            flushD,
  output logic                            flushE,
  output logic [1:0]                      fwdA,
  output logic [1:0]                      fwdB
);
  import cpuPkg::*;

  logic loadUse;

  // newest producer wins, r0 never forwards
  function automatic logic [1:0] pickFwd(input logic [regAddrWidth-1:0] src);
    if (src == '0)
      return fwdNone;
    if (regWriteM && writeRegM == src)
      return fwdMem;
    if (regWriteW && writeRegW == src)
      return fwdWb;
    return fwdNone;
  endfunction

  always_comb begin
    fwdA = pickFwd(rsE);
    fwdB = pickFwd(rtE);
  end

  // load in execute feeding decode, one bubble
  assign loadUse = memReadE && (writeRegE != '0) &&
                   ((writeRegE == rsD) || (writeRegE == rtD));

  assign stallF = loadUse && !branchTakenE;  // redirect overrides the hold
  assign stallD = loadUse && !branchTakenE;
  assign flushD = branchTakenE;              // two younger instrs dropped
  assign flushE = loadUse || branchTakenE;

endmodule

/* verilog/memorySystem.sv */
module memorySystem (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         progWrite,
  input  logic [cpuPkg::dataWidth-1:0] progAddr,
  input  logic [cpuPkg::dataWidth-1:0] progData,
  input  logic [cpuPkg::dataWidth-1:0] instrAddr,
  output logic [cpuPkg::dataWidth-1:0] instr,
  input  logic                         dataReq,
  input  logic                         dataWrite,
  input  logic [cpuPkg::dataWidth-1:0] dataAddr,
  input  logic [cpuPkg::dataWidth-1:0] dataWdata,
  output logic                         dataBusy,
  output logic [cpuPkg::dataWidth-1:0] dataRdata
);
  import cpuPkg::*;

  typedef enum logic {memIdle, memAccess} memStateT;
  typedef logic [$clog2(dmemLatency+1)-1:0] cntT;

  logic [dataWidth-1:0] imem [imemDepth];
  logic [dataWidth-1:0] dmem [dmemDepth];

  memStateT             state;
  cntT                  waitCnt;
  logic                 lastBeat;
  logic                 reqWrite;           // latched request
  logic [dataWidth-1:0] reqAddr, reqWdata;

  ////////////////////////////////////////////////////////////////////////////
  // instruction side, byte addressed, one word per two bytes
  always_ff @(posedge clk) begin
    if (progWrite)
      imem[progAddr[$clog2(imemDepth):1]] <= progData;
  end

  assign instr = imem[instrAddr[$clog2(imemDepth):1]];  // same-cycle read

  ////////////////////////////////////////////////////////////////////////////
  // data side, word addressed, fixed latency
  assign lastBeat = (state == memAccess) && (waitCnt == cntT'(dmemLatency - 1));
  assign dataBusy = (state == memAccess);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= memIdle;
      waitCnt <= '0;
    end else begin
      case (state)
        memIdle:
          if (dataReq) begin
            state   <= memAccess;  // busy from next cycle
            waitCnt <= '0;
          end
        memAccess:
          if (lastBeat)
            state <= memIdle;
          else
            waitCnt <= waitCnt + 1'b1;
        default: state <= memIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == memIdle && dataReq) begin
      reqWrite <= dataWrite;
      reqAddr  <= dataAddr;
      reqWdata <= dataWdata;
    end
    if (lastBeat) begin
      if (reqWrite)
        dmem[reqAddr[$clog2(dmemDepth)-1:0]] <= reqWdata;
      else
        dataRdata <= dmem[reqAddr[$clog2(dmemDepth)-1:0]];  // held until the next read
    end
  end

  // one access in flight, the requester waits out busy
  assert property (@(posedge clk) disable iff (reset) $rose(dataReq) |-> !dataBusy);

endmodule

/* verilog/cpuCore.sv */
module cpuCore (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            run,
  output logic [cpuPkg::dataWidth-1:0]    instrAddr,
  input  logic [cpuPkg::dataWidth-1:0]    instr,
  output logic                            dataReq,
  output logic                            dataWrite,
  output logic [cpuPkg::dataWidth-1:0]    dataAddr,
  output logic [cpuPkg::dataWidth-1:0]    dataWdata,
  input  logic [cpuPkg::dataWidth-1:0]    dataRdata,
  input  logic                            dataBusy,
  output logic                            hlt,
  output logic [cpuPkg::dataWidth-1:0]    pcOut,
  output logic                            wbValid,
  output logic [cpuPkg::regAddrWidth-1:0] wbReg,
  output logic [cpuPkg::dataWidth-1:0]    wbData
);
  import cpuPkg::*;

  // IF
  logic [dataWidth-1:0] pc, pcPlusF;
  logic                 en, busyQ, memDone, fetchStop, haltPending;
  // ID
  logic                    validD;
  logic [dataWidth-1:0]    instrD, pcPlusD, immD, rfDataA, rfDataB;
  opcodeT                  opcodeD;
  aluOpT                   aluOpD;
  brCondT                  brCondD;
  logic [8:0]              brOffD;
  logic [regAddrWidth-1:0] rdD, rsD, rtD;
  logic regWriteD, memToRegD, memWriteD, memReadD, aluSrcD, branchD, haltD, setFlagsD;
  // EX
  logic regWriteE, memToRegE, memWriteE, memReadE, aluSrcE, branchE, haltE, setFlagsE;
  aluOpT                   aluOpE;
  brCondT                  brCondE;
  logic [8:0]              brOffE;
  logic [regAddrWidth-1:0] rsE, rtE, writeRegE;
  logic [dataWidth-1:0]    srcAE, srcBE, immE, pcPlusE, opAE, opBE, aluOutE, targetE;
  logic                    zeroE, ovflE, negE, condMet, branchTakenE;
  logic                    flagZ, flagV, flagN;  // flags register
  // MEM, WB
  logic                    regWriteM, memToRegM, memWriteM, memReadM, haltM;
  logic [regAddrWidth-1:0] writeRegM, writeRegW;
  logic [dataWidth-1:0]    aluOutM, storeDataM, wbDataW;
  logic                    regWriteW, haltW;
  // hazard controls
  logic       stallF, stallD, flushD, flushE;
  logic [1:0] fwdA, fwdB;

  ////////////////////////////////////////////////////////////////////////////
  // fetch and global stall

  // a data access stalls from its request until the cycle busy drops
  assign memDone   = busyQ && !dataBusy;              // rdata valid now
  assign dataReq   = (memReadM || memWriteM) && !memDone;
  assign en        = run && !dataBusy && !dataReq;    // one enable for all stages
  assign pcPlusF   = pc + dataWidth'(pcStep);
  assign fetchStop = (haltD && validD) || haltPending; // no fetch past HLT
  assign instrAddr = pc;
  assign pcOut     = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      busyQ       <= 1'b0;
      haltPending <= 1'b0;
    end else begin
      busyQ <= dataBusy;
      if (en) begin
        if (branchTakenE)
          pc <= targetE;                              // redirect wins over stalls
        else if (!stallF && !fetchStop)
          pc <= pcPlusF;
        if (haltD && validD && !flushE)
          haltPending <= 1'b1;                        // HLT went into execute
      end
    end
  end

  // IF/ID register holds a bubble as a zero word with valid low
  always_ff @(posedge clk) begin
    if (reset) begin
      validD <= 1'b0;
      instrD <= '0;
    end else if (en) begin
      if (flushD) begin
        validD <= 1'b0;
        instrD <= '0;
      end else if (stallD) begin
        validD <= validD;                             // load-use hold
      end else if (fetchStop) begin
        validD <= 1'b0;
        instrD <= '0;
      end else begin
        validD  <= 1'b1;
        instrD  <= instr;
        pcPlusD <= pcPlusF;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode

  instrDecoder dec (
    .instr(instrD), .opcode(opcodeD), .rd(rdD), .rs(rsD), .rt(rtD), .imm(immD),
    .brCond(brCondD), .brOff(brOffD), .regWrite(regWriteD), .memToReg(memToRegD),
    .memWrite(memWriteD), .memRead(memReadD), .aluSrc(aluSrcD), .branch(branchD),
    .halt(haltD), .aluOp(aluOpD)
  );

  registerFile regs (
    .clk(clk), .reset(reset), .srcReg1(rsD), .srcReg2(rtD),
    .dstReg(writeRegW), .writeReg(regWriteW), .dstData(wbDataW),
    .srcData1(rfDataA), .srcData2(rfDataB)
  );

  hazardUnit hzd (
    .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
    .memReadE(memReadE), .regWriteM(regWriteM), .regWriteW(regWriteW),
    .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
    .branchTakenE(branchTakenE), .stallF(stallF), .stallD(stallD),
    .flushD(flushD), .flushE(flushE), .fwdA(fwdA), .fwdB(fwdB)
  );

  assign setFlagsD = opcodeD inside {ADD, SUB, XOR};

  // ID/EX control
  always_ff @(posedge clk) begin
    if (reset) begin
      {regWriteE, memToRegE, memWriteE, memReadE, branchE, haltE, setFlagsE} <= '0;
    end else if (en) begin
      if (flushE || !validD)
        {regWriteE, memToRegE, memWriteE, memReadE, branchE, haltE, setFlagsE} <= '0;
      else
        {regWriteE, memToRegE, memWriteE, memReadE, branchE, haltE, setFlagsE} <=
          {regWriteD, memToRegD, memWriteD, memReadD, branchD, haltD, setFlagsD};
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    if (en) begin
      aluOpE  <= aluOpD;
      brCondE <= brCondD;
      {aluSrcE, brOffE}             <= {aluSrcD, brOffD};
      {rsE, rtE, writeRegE}         <= {rsD, rtD, rdD};
      {srcAE, srcBE, immE, pcPlusE} <= {rfDataA, rfDataB, immD, pcPlusD};
    end else begin
      srcAE <= opAE;                                  // keep forwarded operands while frozen
      srcBE <= opBE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // execute

  function automatic logic [dataWidth-1:0] fwdMux(input logic [1:0] sel,
                                                  input logic [dataWidth-1:0] regVal);
    case (sel)
      fwdMem:  return aluOutM;
      fwdWb:   return wbDataW;
      default: return regVal;
    endcase
  endfunction

  always_comb begin
    opAE = fwdMux(fwdA, srcAE);
    opBE = fwdMux(fwdB, srcBE);
  end

  alu exAlu (
    .aluOp(aluOpE), .a(opAE), .b(aluSrcE ? immE : opBE), .result(aluOutE),
    .zero(zeroE), .overflow(ovflE), .negative(negE)
  );

  always_comb begin
    unique case (brCondE)
      NEQ:    condMet = !flagZ;
      EQ:     condMet = flagZ;
      GT:     condMet = !flagZ && !flagN;
      LT:     condMet = flagN;
      GTE:    condMet = flagZ || !flagN;
      LTE:    condMet = flagZ || flagN;
      OVFL:   condMet = flagV;
      UNCOND: condMet = 1'b1;
    endcase
  end

  assign branchTakenE = branchE && condMet;
  assign targetE = pcPlusE + {{(dataWidth-10){brOffE[8]}}, brOffE, 1'b0}; // word offset

  always_ff @(posedge clk) begin
    if (reset)
      {flagZ, flagV, flagN} <= '0;
    else if (en && setFlagsE)
      {flagZ, flagV, flagN} <= {zeroE, ovflE, negE};  // only ADD, SUB, XOR
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory and writeback

  always_ff @(posedge clk) begin
    if (reset)
      {regWriteM, memToRegM, memWriteM, memReadM, haltM} <= '0;
    else if (en)
      {regWriteM, memToRegM, memWriteM, memReadM, haltM} <=
        {regWriteE, memToRegE, memWriteE, memReadE, haltE};
  end

  always_ff @(posedge clk) begin
    if (en) begin
      writeRegM  <= writeRegE;
      aluOutM    <= aluOutE;
      storeDataM <= opBE;                             // forwarded rt is the SW data
    end
  end

  assign dataWrite = memWriteM;
  assign dataAddr  = aluOutM;
  assign dataWdata = storeDataM;

  // WB takes a bubble on every frozen cycle, so each result is traced once
  always_ff @(posedge clk) begin
    if (reset || !en)
      {regWriteW, haltW} <= '0;
    else
      {regWriteW, haltW} <= {regWriteM, haltM};
    writeRegW <= writeRegM;
    wbDataW   <= memToRegM ? dataRdata : aluOutM;
  end

  always_ff @(posedge clk) begin
    if (reset)
      hlt <= 1'b0;
    else if (haltW)
      hlt <= 1'b1;                                    // sticky
  end

  assign wbValid = regWriteW;
  assign wbReg   = writeRegW;
  assign wbData  = wbDataW;

  // once halted the pc stays parked and nothing more retires
  assert property (@(posedge clk) disable iff (reset)
    hlt |=> hlt && $stable(pc) && !wbValid);
  // a busy memory freezes the pipe, so no result retires meanwhile
  assert property (@(posedge clk) disable iff (reset) dataBusy |-> !wbValid);

endmodule

/* verilog/cpu.sv */
module cpu (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            run,        // high lets the core fetch
  input  logic                            progWrite,
  input  logic [cpuPkg::dataWidth-1:0]    progAddr,   // byte address
  input  logic [cpuPkg::dataWidth-1:0]    progData,
  output logic                            hlt,
  output logic [cpuPkg::dataWidth-1:0]    pcOut,
  output logic                            wbValid,
  output logic [cpuPkg::regAddrWidth-1:0] wbReg,
  output logic [cpuPkg::dataWidth-1:0]    wbData
);
  import cpuPkg::*;

  logic [dataWidth-1:0] instrAddr, instr;             // fetch path
  logic                 dataReq, dataWrite, dataBusy; // data handshake
  logic [dataWidth-1:0] dataAddr, dataWdata, dataRdata;

  cpuCore core (
    .clk(clk), .reset(reset), .run(run),
    .instrAddr(instrAddr), .instr(instr),
    .dataReq(dataReq), .dataWrite(dataWrite),
    .dataAddr(dataAddr), .dataWdata(dataWdata),
    .dataRdata(dataRdata), .dataBusy(dataBusy),
    .hlt(hlt), .pcOut(pcOut),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  memorySystem mem (
    .clk(clk), .reset(reset),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .instrAddr(instrAddr), .instr(instr),
    .dataReq(dataReq), .dataWrite(dataWrite),
    .dataAddr(dataAddr), .dataWdata(dataWdata),
    .dataBusy(dataBusy), .dataRdata(dataRdata)
  );

endmodule

/* bench/tbClock.sv */
module tbClock (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 2;

  initial begin
    clk   = 1'b0;
    reset = 1'b1;  // held from time zero
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
  end

  always #2 clk = ~clk;  // 4 ns period

endmodule

/* bench/cpuChecker.sv */
module cpuChecker (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            wbValid,
  input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
  input  logic [cpuPkg::dataWidth-1:0]    wbData,
  input  logic                            hlt,
  input  logic [cpuPkg::dataWidth-1:0]    pcOut,
  output int                              errors,
  output int                              checked,
  output logic                            done
);
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  localparam int holdCycles = 8;  // quiet cycles watched after hlt

  logic [23:0]             stim [256];  // kind, reg, data
  logic [regAddrWidth-1:0] expReg [$];
  logic [dataWidth-1:0]    expData [$];
  logic [dataWidth-1:0]    expHaltPc;
  int                      haltCycles;

  ////////////////////////////////////////////////////////////////////////////
  // expected values, kind 2 and kind 3 records
  initial begin
    errors     = 0;
    checked    = 0;
    done       = 1'b0;
    haltCycles = 0;
    expHaltPc  = '0;
    foreach (stim[i]) stim[i] = '0;  // kind 0 marks unused slots
    $readmemh("bench/cpuStim.txt", stim);
    foreach (stim[i]) begin
      if (stim[i][23:20] == 4'h2) begin
        expReg.push_back(stim[i][19:16]);
        expData.push_back(stim[i][15:0]);
      end else if (stim[i][23:20] == 4'h3) begin
        expHaltPc = stim[i][15:0];
      end
    end
  end

  // next trace beat against the head of the expected list
  task automatic compareWriteback();
    logic [regAddrWidth-1:0] r;
    logic [dataWidth-1:0]    d;
    if (expReg.size() == 0) begin
      $display("unexpected writeback to r%0d, no expected entry left", wbReg);
      errors++;
    end else begin
      r = expReg.pop_front();
      d = expData.pop_front();
      if (wbReg !== r) begin
        $display("** Error: wbReg = %h, expected %h (writeback %0d)", wbReg, r, checked);
        errors++;
      end
      if (wbData !== d) begin
        $display("** Error: wbData = %h, expected %h (writeback %0d)", wbData, d, checked);
        errors++;
      end
      checked++;
    end
  endtask

  task automatic verifyHalt();
    if (pcOut !== expHaltPc) begin
      $display("** Error: pcOut = %h, expected %h", pcOut, expHaltPc);
      errors++;
    end
    if (expReg.size() != 0) begin
      $display("core halted with %0d expected writebacks still missing", expReg.size());
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampled mid-cycle, DUT outputs settled
  always @(negedge clk) begin
    if (reset === 1'b0 && !done) begin
      if (haltCycles == 0) begin
        if (wbValid) compareWriteback();
        if (hlt) begin
          verifyHalt();
          haltCycles = 1;
        end
      end else begin
        if (wbValid) begin
          $display("writeback to r%0d after the core halted", wbReg);
          errors++;
        end
        if (!hlt) begin
          $display("hlt dropped without reset");
          errors++;
        end
        haltCycles++;
        if (haltCycles > holdCycles) done <= 1'b1;  // pipe stayed quiet
      end
    end
  end

endmodule

/* bench/cpuBench.sv */
module cpuBench;
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  logic                    clk, reset, run, progWrite;
  logic [dataWidth-1:0]    progAddr, progData;
  logic                    hlt, wbValid;
  logic [dataWidth-1:0]    pcOut, wbData;
  logic [regAddrWidth-1:0] wbReg;
  int                      errors, checked, progWords;
  logic                    checkDone;
  logic [23:0]             stim [256];  // same records the checker reads

  tbClock clkGen (.clk(clk), .reset(reset));

  cpu u_dut (
    .clk(clk), .reset(reset), .run(run),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .hlt(hlt), .pcOut(pcOut),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  cpuChecker chk (
    .clk(clk), .reset(reset),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .hlt(hlt), .pcOut(pcOut),
    .errors(errors), .checked(checked), .done(checkDone)
  );

  ////////////////////////////////////////////////////////////////////////////
  // program load, then run
  initial begin
    run       = 1'b0;
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    progWords = 0;
    foreach (stim[i]) stim[i] = '0;
    $readmemh("bench/cpuStim.txt", stim);

    @(posedge clk);
    while (reset !== 1'b0) @(posedge clk);

    // one word per edge, byte addresses step by pcStep
    foreach (stim[i]) begin
      if (stim[i][23:20] == 4'h1) begin
        progWrite <= 1'b1;
        progAddr  <= dataWidth'(pcStep * progWords);
        progData  <= stim[i][15:0];
        progWords++;
        @(posedge clk);
      end
    end
    progWrite <= 1'b0;
    run       <= 1'b1;  // fetch starts at pc 0

    wait (checkDone === 1'b1);
    @(posedge clk);
    $display("%0d writebacks checked, %0d errors", checked, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // watchdog, budget grows with program length
  initial begin
    int limit;
    wait (run === 1'b1);
    limit = 40 * progWords + 500;
    repeat (limit) @(posedge clk);
    $display("timeout: core did not halt within %0d cycles", limit);
    $display("%0d writebacks checked, %0d errors", checked, errors);
    $display("Errors found");
    $finish;
  end

endmodule

/* bench/cpuStim.txt */
// columns kind_reg_data, kind 1 = program word, 2 = expected writeback (reg, value),
// 3 = expected halt pc; program words in address order, writebacks in retire order
// constants, then arithmetic with back-to-back forwarding
1_0_A105 1_0_A203 1_0_0312 1_0_1431
1_0_2543 1_0_4654 1_0_5762 1_0_B87F
// saturating add and sub, LT taken, EQ not taken
1_0_A8FF 1_0_0981 1_0_BA80 1_0_1BA2
1_0_C602 1_0_AC11 1_0_AD22 1_0_C202
// EQ taken after a zero XOR, r0 write then r0 read
1_0_AC33 1_0_2E11 1_0_C202 1_0_AD44
1_0_0F11 1_0_A055 1_0_0D02 1_0_9921
// store then load, load-use add, UNCOND over a HLT
1_0_8621 1_0_076B 1_0_CE02 1_0_AF66
1_0_F000 1_0_AF77 1_0_14F7 1_0_F000
// expected writebacks
2_1_0005 2_2_0003 2_3_0008 2_4_0003
2_5_000B 2_6_00B0 2_7_002C 2_8_7F00
2_8_7FFF 2_9_7FFF 2_A_8000 2_B_8000
2_C_0033 2_E_0000 2_0_0055 2_D_0003
2_6_7FFF 2_7_FFFF 2_F_0077 2_4_0078
// last HLT sits at 0x3E
3_0_0040

/* vlog.f */
verilog/cpuPkg.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/instrDecoder.sv
verilog/hazardUnit.sv
verilog/memorySystem.sv
verilog/cpuCore.sv
verilog/cpu.sv
bench/tbClock.sv
bench/cpuChecker.sv
bench/cpuBench.sv
